// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 --top-module zap_tb -f src.f -o zap_sim \
        || { echo "Build failed."; exit 1; }
./obj_dir/zap_sim > sim.log 2>&1 || echo "Simulator exited with an error."
cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed."; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended without a result."; exit 1; }
echo "Simulation passed."

// ==== sim/zap_tb_tasks.svh ====
/*
 * Wishbone slave model and directed tests for the bus front end.
 * Outputs are sampled one time unit after the falling edge.
 */

task automatic check_idle_outputs();
        check_val("o_wb_cyc", 32'(o_wb_cyc), 32'd0);
        check_val("o_wb_stb", 32'(o_wb_stb), 32'd0);
        check_val("o_instr_ack", 32'(o_instr_ack), 32'd0);
        check_val("o_data_ack", 32'(o_data_ack), 32'd0);
        check_val("o_irq", 32'(o_irq), 32'd0);
        check_val("o_fiq", 32'(o_fiq), 32'd0);
        check_val("o_wb_cti", 32'(o_wb_cti), 32'(zap_pkg::ZAP_CTI_EOB));
        check_val("o_wb_bte", 32'(o_wb_bte), 32'(zap_pkg::ZAP_BTE_LINEAR));
endtask

// ------------------------------
// Slave model
// ------------------------------

task automatic wait_bus_stb();
        int n;
        n = 0;
        while (!o_wb_stb && n < TIMEOUT)
        begin
                @(negedge i_clk);
                #1;
                n++;
        end
        if (!o_wb_stb)
        begin
                $display("Timeout, the Wishbone strobe never rose.");
                $display("TESTS FAILED");
                $fatal(1, "Bus strobe timeout.");
        end
endtask

// Stalls dly cycles, then acks with rdat and drops the served strobe.
task automatic serve(input logic to_data, input logic [31:0] exp_adr, input int dly,
                     input logic [31:0] rdat);
        logic [31:0] dat_s;
        logic [3:0]  sel_s;
        logic        we_s;
        int          n;
        wait_bus_stb();
        check_val("o_wb_cyc", 32'(o_wb_cyc), 32'd1);
        check_val("o_wb_adr", o_wb_adr, exp_adr);
        dat_s = o_wb_dat;
        sel_s = o_wb_sel;
        we_s  = o_wb_we;
        for (n = 0; n < dly; n++)
        begin
                @(negedge i_clk);
                #1;
                check_val("o_wb_cyc", 32'(o_wb_cyc), 32'd1);
                check_val("o_wb_stb", 32'(o_wb_stb), 32'd1);
                check_val("o_wb_adr", o_wb_adr, exp_adr);
                check_val("o_wb_dat", o_wb_dat, dat_s);
                check_val("o_wb_sel", 32'(o_wb_sel), 32'(sel_s));
                check_val("o_wb_we", 32'(o_wb_we), 32'(we_s));
                check_val("o_instr_ack", 32'(o_instr_ack), 32'd0);
                check_val("o_data_ack", 32'(o_data_ack), 32'd0);
        end
        @(negedge i_clk);
        i_wb_ack = 1'b1;
        i_wb_dat = rdat;
        #1;
        check_val("o_instr_ack", 32'(o_instr_ack), 32'(!to_data));
        check_val("o_data_ack", 32'(o_data_ack), 32'(to_data));
        if (to_data)
                check_val("o_data_dat", o_data_dat, swap_word(rdat));
        else
                check_val("o_instr_dat", o_instr_dat, swap_word(rdat));
        @(negedge i_clk);
        i_wb_ack = 1'b0;
        if (to_data)
                i_data_stb = 1'b0;
        else
                i_instr_stb = 1'b0;
        #1;
        check_val("o_wb_cyc", 32'(o_wb_cyc), 32'd0);
        check_val("o_wb_stb", 32'(o_wb_stb), 32'd0);
endtask

// Request seen in idle must reach the bus exactly one cycle later.
task automatic check_grant_delay();
        #1;
        check_val("o_wb_stb", 32'(o_wb_stb), 32'd0);
        @(negedge i_clk);
        #1;
        check_val("o_wb_stb", 32'(o_wb_stb), 32'd1);
endtask

// ------------------------------
// Directed tests
// ------------------------------

task automatic test_code_read();
        logic [31:0] adr;
        adr = rand_bits(32);
        @(negedge i_clk);
        i_instr_stb = 1'b1;
        i_instr_adr = adr;
        check_grant_delay();
        check_val("o_wb_we", 32'(o_wb_we), 32'd0);
        check_val("o_wb_sel", 32'(o_wb_sel), 32'hF);
        serve(1'b0, adr, 0, rand_bits(32));
endtask

task automatic start_data(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                          input logic [31:0] wdat);
        i_data_stb = 1'b1;
        i_data_we  = we;
        i_data_adr = adr;
        i_data_sel = sel;
        i_data_dat = wdat;
endtask

task automatic test_data_write_read();
        logic [31:0] adr;
        logic [31:0] wdat;
        logic [3:0]  sel;
        adr  = rand_bits(32);
        sel  = {1'b0, 2'(rand_bits(2)), 1'b1}; // Lane 0 set, lane 3 clear.
        wdat = rand_bits(32);
        @(negedge i_clk);
        start_data(1'b1, adr, sel, wdat);
        check_grant_delay();
        check_val("o_wb_we", 32'(o_wb_we), 32'd1);
        check_val("o_wb_sel", 32'(o_wb_sel), 32'(mirror_sel(sel)));
        check_val("o_wb_dat", o_wb_dat, wdat);
        serve(1'b1, adr, 0, rand_bits(32));
        adr = rand_bits(32);
        @(negedge i_clk);
        start_data(1'b0, adr, 4'hF, '0);
        check_grant_delay();
        check_val("o_wb_we", 32'(o_wb_we), 32'd0);
        serve(1'b1, adr, 0, rand_bits(32));
endtask

task automatic test_round_robin();
        logic [31:0] code_a;
        logic [31:0] data_a;
        test_code_read(); // Code was served last.
        code_a = rand_bits(32);
        data_a = rand_bits(32);
        @(negedge i_clk);
        i_instr_stb = 1'b1;
        i_instr_adr = code_a;
        start_data(1'b0, data_a, 4'hF, '0);
        #1;
        serve(1'b1, data_a, 0, rand_bits(32));
        serve(1'b0, code_a, 0, rand_bits(32));
        data_a = rand_bits(32);
        @(negedge i_clk);
        start_data(1'b0, data_a, 4'hF, '0);
        #1;
        serve(1'b1, data_a, 0, rand_bits(32)); // Data was served last.
        code_a = rand_bits(32);
        data_a = rand_bits(32);
        @(negedge i_clk);
        i_instr_stb = 1'b1;
        i_instr_adr = code_a;
        start_data(1'b0, data_a, 4'hF, '0);
        #1;
        serve(1'b0, code_a, 0, rand_bits(32));
        serve(1'b1, data_a, 0, rand_bits(32));
endtask

task automatic test_back_pressure();
        logic [31:0] adr;
        adr = rand_bits(32);
        @(negedge i_clk);
        i_instr_stb = 1'b1;
        i_instr_adr = adr;
        #1;
        serve(1'b0, adr, 1 + int'(rand_bits(3)), rand_bits(32));
        adr = rand_bits(32);
        @(negedge i_clk);
        start_data(1'b1, adr, 4'(rand_bits(4)), rand_bits(32));
        #1;
        serve(1'b1, adr, 1 + int'(rand_bits(3)), rand_bits(32));
endtask

// Output follows the line exactly two rising edges after the change.
task automatic check_sync_edge(input logic fiq_line, input logic level);
        @(negedge i_clk);
        if (fiq_line)
                i_fiq = level;
        else
                i_irq = level;
        #1;
        check_val(fiq_line ? "o_fiq" : "o_irq", 32'(fiq_line ? o_fiq : o_irq), 32'(!level));
        @(negedge i_clk);
        #1;
        check_val(fiq_line ? "o_fiq" : "o_irq", 32'(fiq_line ? o_fiq : o_irq), 32'(!level));
        @(negedge i_clk);
        #1;
        check_val(fiq_line ? "o_fiq" : "o_irq", 32'(fiq_line ? o_fiq : o_irq), 32'(level));
endtask

task automatic test_irq_sync();
        check_sync_edge(1'b0, 1'b1);
        check_sync_edge(1'b1, 1'b1);
        check_sync_edge(1'b0, 1'b0);
        check_sync_edge(1'b1, 1'b0);
endtask

// ==== sim/zap_tb.sv ====
/*
 * Testbench for the ZAP bus front end. Drives both request channels and
 * the interrupt lines, models the Wishbone slave and checks the bus.
 */

`default_nettype none

module zap_tb;

localparam int TIMEOUT = 100; // Cycles allowed for any wait.

logic                                   i_clk;
logic                                   i_rst_n;
logic                                   i_irq;
logic                                   i_fiq;
logic                                   o_irq;
logic                                   o_fiq;
logic                                   i_instr_stb;
logic [zap_pkg::ZAP_WORD_W-1:0]         i_instr_adr;
logic                                   o_instr_ack;
logic [zap_pkg::ZAP_WORD_W-1:0]         o_instr_dat;
logic                                   i_data_stb;
logic                                   i_data_we;
logic [zap_pkg::ZAP_WORD_W-1:0]         i_data_adr;
logic [zap_pkg::ZAP_SEL_W-1:0]          i_data_sel;
logic [zap_pkg::ZAP_WORD_W-1:0]         i_data_dat;
logic                                   o_data_ack;
logic [zap_pkg::ZAP_WORD_W-1:0]         o_data_dat;
logic                                   o_wb_cyc;
logic                                   o_wb_stb;
logic [zap_pkg::ZAP_WORD_W-1:0]         o_wb_adr;
logic                                   o_wb_we;
logic [zap_pkg::ZAP_WORD_W-1:0]         o_wb_dat;
logic [zap_pkg::ZAP_SEL_W-1:0]          o_wb_sel;
logic [2:0]                             o_wb_cti;
logic [1:0]                             o_wb_bte;
logic                                   i_wb_ack;
logic [zap_pkg::ZAP_WORD_W-1:0]         i_wb_dat;

logic [15:0]    lfsr_q;

// Port names match the signals above.
zap_top #(.BE_32_ENABLE(1'b1)) dut (.*);

initial
begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
end

// ------------------------------
// Helpers
// ------------------------------

// Galois LFSR, one step per bit taken.
function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        int          i;
        val = '0;
        for (i = 0; i < n; i++)
        begin
                val    = {val[30:0], lfsr_q[0]};
                lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return val;
endfunction

// Byte 0 of the slave word lands in byte 3 of the channel word.
function automatic logic [31:0] swap_word(input logic [31:0] w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

function automatic logic [3:0] mirror_sel(input logic [3:0] s);
        return {s[0], s[1], s[2], s[3]};
endfunction

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
                $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
                $display("TESTS FAILED");
                $fatal(1, "Value mismatch on %s.", name);
        end
endtask

`include "zap_tb_tasks.svh"

// ------------------------------
// Test sequence
// ------------------------------

initial
begin
        lfsr_q      = 16'd49688;
        i_rst_n     = 1'b0;
        i_irq       = 1'b0;
        i_fiq       = 1'b0;
        i_instr_stb = 1'b0;
        i_instr_adr = '0;
        i_data_stb  = 1'b0;
        i_data_we   = 1'b0;
        i_data_adr  = '0;
        i_data_sel  = '0;
        i_data_dat  = '0;
        i_wb_ack    = 1'b0;
        i_wb_dat    = '0;
        repeat (8) @(negedge i_clk);
        #1;
        check_idle_outputs(); // Mid reset.
        repeat (8) @(negedge i_clk);
        i_rst_n = 1'b1;
        #1;
        check_idle_outputs();
        test_code_read();
        test_data_write_read();
        test_round_robin();
        test_back_pressure();
        test_irq_sync();
        $display("TESTS PASSED");
        $finish;
end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+sim
verilog/zap_pkg.sv
verilog/zap_req_if.sv
verilog/zap_dual_rank_synchronizer.sv
verilog/zap_wb_merger.sv
verilog/zap_top.sv
sim/zap_tb.sv

// ==== verilog/zap_dual_rank_synchronizer.sv ====
/*
 * Two-flop synchronizer for asynchronous level inputs. Each bit passes
 * through two registered ranks, so a change shows two edges later.
 */

`default_nettype none

module zap_dual_rank_synchronizer #(
        parameter int WIDTH = 2
)(
        input  logic             i_clk,
        input  logic             i_rst_n,
        input  logic [WIDTH-1:0] i_in,   // Asynchronous levels.
        output logic [WIDTH-1:0] o_out   // Synchronized levels.
);

// ------------------------------
// Metastability ranks
// ------------------------------

logic [WIDTH-1:0] rank1_q; // May go metastable.
logic [WIDTH-1:0] rank2_q; // Settled copy.

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                rank1_q <= '0;
                rank2_q <= '0;
        end
        else
        begin
                rank1_q <= i_in;
                rank2_q <= rank1_q;
        end
end

assign o_out = rank2_q;

endmodule

`default_nettype wire

// ==== verilog/zap_pkg.sv ====
/*
 * Shared definitions for the ZAP bus front end. Holds the bus widths,
 * the fixed Wishbone cycle and burst codes and a word type that can be
 * read either whole or byte by byte.
 */

`default_nettype none

package zap_pkg;

        // ------------------------------
        // Bus widths
        // ------------------------------

        localparam int ZAP_WORD_W = 32; // Address and data width.
        localparam int ZAP_SEL_W  = 4;  // One select per byte lane.

        // ------------------------------
        // Wishbone codes
        // ------------------------------

        // No bursts are issued, every cycle is a single transfer.
        localparam logic [2:0] ZAP_CTI_EOB    = 3'b111; // End of burst.
        localparam logic [1:0] ZAP_BTE_LINEAR = 2'b00;  // Linear burst.

        // ------------------------------
        // Byte-addressable word
        // ------------------------------

        // Byte 0 sits in bits 7:0.
        typedef union packed
        {
                logic [ZAP_WORD_W-1:0]          word;
                logic [ZAP_SEL_W-1:0][7:0]      bytes;
        } zap_word_t;

endpackage

`default_nettype wire

// ==== verilog/zap_req_if.sv ====
/*
 * Request channel between a bus master and the Wishbone merger.
 * Classic handshake, the master holds its strobe until acknowledged.
 */

`default_nettype none

interface zap_req_if;

        // ------------------------------
        // Channel signals
        // ------------------------------

        logic                           stb;    // Request strobe.
        logic [zap_pkg::ZAP_WORD_W-1:0] adr;    // Byte address.
        logic                           ack;    // Single cycle acknowledge.
        logic [zap_pkg::ZAP_WORD_W-1:0] rdat;   // Read data, valid with ack.

        // Requesting side.
        modport master
        (
                output stb,
                output adr,
                input  ack,
                input  rdat
        );

        // Serving side.
        modport slave
        (
                input  stb,
                input  adr,
                output ack,
                output rdat
        );

endinterface

`default_nettype wire

// ==== verilog/zap_top.sv ====
/*
 * ZAP bus front end. Merges the instruction and data request channels
 * onto one Wishbone classic port and synchronizes the interrupt lines.
 */

`default_nettype none

module zap_top #(
        parameter logic [0:0] BE_32_ENABLE = 1'b1 // BE-32 lane swap.
)(
        // ------------------------------
        // Clock and reset
        // ------------------------------

        input  logic                            i_clk,
        input  logic                            i_rst_n,

        // ------------------------------
        // Interrupts
        // ------------------------------

        // Active high, level triggered, asynchronous.
        input  logic                            i_irq,
        input  logic                            i_fiq,
        output logic                            o_irq,
        output logic                            o_fiq,

        // ------------------------------
        // Instruction channel
        // ------------------------------

        input  logic                            i_instr_stb,
        input  logic [zap_pkg::ZAP_WORD_W-1:0]  i_instr_adr,
        output logic                            o_instr_ack,
        output logic [zap_pkg::ZAP_WORD_W-1:0]  o_instr_dat,

        // ------------------------------
        // Data channel
        // ------------------------------

        input  logic                            i_data_stb,
        input  logic                            i_data_we,
        input  logic [zap_pkg::ZAP_WORD_W-1:0]  i_data_adr,
        input  logic [zap_pkg::ZAP_SEL_W-1:0]   i_data_sel,
        input  logic [zap_pkg::ZAP_WORD_W-1:0]  i_data_dat,
        output logic                            o_data_ack,
        output logic [zap_pkg::ZAP_WORD_W-1:0]  o_data_dat,

        // ------------------------------
        // Wishbone port
        // ------------------------------

        output logic                            o_wb_cyc,
        output logic                            o_wb_stb,
        output logic [zap_pkg::ZAP_WORD_W-1:0]  o_wb_adr,
        output logic                            o_wb_we,
        output logic [zap_pkg::ZAP_WORD_W-1:0]  o_wb_dat,
        output logic [zap_pkg::ZAP_SEL_W-1:0]   o_wb_sel,
        output logic [2:0]                      o_wb_cti,
        output logic [1:0]                      o_wb_bte,
        input  logic                            i_wb_ack,
        input  logic [zap_pkg::ZAP_WORD_W-1:0]  i_wb_dat
);

zap_req_if code_req ();  // Instruction fetch channel.
zap_req_if data_req ();  // Load and store channel.

// Master side of both channels comes from the plain ports.
assign code_req.stb = i_instr_stb;
assign code_req.adr = i_instr_adr;
assign o_instr_ack  = code_req.ack;
assign o_instr_dat  = code_req.rdat;

assign data_req.stb = i_data_stb;
assign data_req.adr = i_data_adr;
assign o_data_ack   = data_req.ack;
assign o_data_dat   = data_req.rdat;

// Single transfers only.
assign o_wb_cti = zap_pkg::ZAP_CTI_EOB;
assign o_wb_bte = zap_pkg::ZAP_BTE_LINEAR;

// Interrupt synchronizer.
zap_dual_rank_synchronizer #(
        .WIDTH          (2)
) u_sync (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_in           ({i_fiq, i_irq}),
        .o_out          ({o_fiq, o_irq})
);

// Channel arbiter onto the external bus.
zap_wb_merger #(
        .BE_32_ENABLE   (BE_32_ENABLE)
) u_zap_wb_merger (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .code           (code_req),
        .data           (data_req),
        .i_data_we      (i_data_we),
        .i_data_sel     (i_data_sel),
        .i_data_wdat    (i_data_dat),
        .o_wb_cyc       (o_wb_cyc),
        .o_wb_stb       (o_wb_stb),
        .o_wb_we        (o_wb_we),
        .o_wb_adr       (o_wb_adr),
        .o_wb_sel       (o_wb_sel),
        .o_wb_dat       (o_wb_dat),
        .i_wb_ack       (i_wb_ack),
        .i_wb_dat       (i_wb_dat)
);

endmodule

`default_nettype wire

// ==== verilog/zap_wb_merger.sv ====
/*
 * Wishbone merger. Arbitrates round-robin between the code and data
 * request channels and routes the winner onto one classic Wishbone port.
 * Optionally applies the BE-32 byte lane swap on selects and read data.
 */

`default_nettype none

module zap_wb_merger #(
        parameter logic [0:0] BE_32_ENABLE = 1'b1
)(
        // ------------------------------
        // Clock and reset
        // ------------------------------

        input  logic                            i_clk,
        input  logic                            i_rst_n,

        // ------------------------------
        // Request channels
        // ------------------------------

        zap_req_if.slave                        code,
        zap_req_if.slave                        data,
        input  logic                            i_data_we,      // Write request.
        input  logic [zap_pkg::ZAP_SEL_W-1:0]   i_data_sel,     // Byte selects.
        input  logic [zap_pkg::ZAP_WORD_W-1:0]  i_data_wdat,    // Write data.

        // ------------------------------
        // Wishbone master port
        // ------------------------------

        output logic                            o_wb_cyc,
        output logic                            o_wb_stb,
        output logic                            o_wb_we,
        output logic [zap_pkg::ZAP_WORD_W-1:0]  o_wb_adr,
        output logic [zap_pkg::ZAP_SEL_W-1:0]   o_wb_sel,
        output logic [zap_pkg::ZAP_WORD_W-1:0]  o_wb_dat,
        input  logic                            i_wb_ack,
        input  logic [zap_pkg::ZAP_WORD_W-1:0]  i_wb_dat
);

localparam int SEL_W = zap_pkg::ZAP_SEL_W;

// Grant encodings.
localparam logic [1:0] GNT_IDLE = 2'd0;
localparam logic [1:0] GNT_CODE = 2'd1;
localparam logic [1:0] GNT_DATA = 2'd2;

logic [1:0]             gnt_q;          // Current owner of the bus.
logic [1:0]             gnt_d;
logic                   last_data_q;    // Set when data won last.
logic [SEL_W-1:0]       data_sel_bus;   // Data selects as seen on the bus.
zap_pkg::zap_word_t     rd_raw;         // Read word from the slave.
zap_pkg::zap_word_t     rd_swp;         // Read word toward the channels.

// ------------------------------
// Grant decision
// ------------------------------

always_comb
begin
        gnt_d = gnt_q;

        case (gnt_q)
        GNT_IDLE:
        begin
                // Both asking, the one that lost last time goes first.
                if (code.stb && data.stb)
                        gnt_d = last_data_q ? GNT_CODE : GNT_DATA;
                else if (code.stb)
                        gnt_d = GNT_CODE;
                else if (data.stb)
                        gnt_d = GNT_DATA;
        end

        GNT_CODE, GNT_DATA:
        begin
                if (i_wb_ack)
                        gnt_d = GNT_IDLE; // Transfer done.
        end

        default:
                gnt_d = GNT_IDLE;
        endcase
end

always_ff @(posedge i_clk or negedge i_rst_n)
begin
        if (!i_rst_n)
        begin
                gnt_q       <= GNT_IDLE;
                last_data_q <= 1'b0; // Code counts as last served.
        end
        else
        begin
                gnt_q <= gnt_d;

                // Remember the winner when a new grant is made.
                if (gnt_q == GNT_IDLE && gnt_d != GNT_IDLE)
                        last_data_q <= (gnt_d == GNT_DATA);
        end
end

// ------------------------------
// BE-32 lane swap
// ------------------------------

assign rd_raw.word = i_wb_dat;

generate
if (BE_32_ENABLE)
begin : g_be32
        always_comb
        begin
                for (int i = 0; i < SEL_W; i++)
                begin
                        data_sel_bus[i] = i_data_sel[SEL_W-1-i]; // Mirror selects.
                        rd_swp.bytes[i] = rd_raw.bytes[SEL_W-1-i]; // Mirror bytes.
                end
        end
end
else
begin : g_le
        assign data_sel_bus = i_data_sel;
        assign rd_swp       = rd_raw;
end
endgenerate

// ------------------------------
// Bus routing
// ------------------------------

always_comb
begin
        o_wb_cyc = 1'b0;
        o_wb_stb = 1'b0;
        o_wb_we  = 1'b0;
        o_wb_adr = '0;
        o_wb_sel = '0;
        o_wb_dat = '0;

        case (gnt_q)
        GNT_CODE:
        begin
                // Instruction fetch, always a full word read.
                o_wb_cyc = 1'b1;
                o_wb_stb = 1'b1;
                o_wb_we  = 1'b0;
                o_wb_adr = code.adr;
                o_wb_sel = '1;
        end

        GNT_DATA:
        begin
                o_wb_cyc = 1'b1;
                o_wb_stb = 1'b1;
                o_wb_we  = i_data_we;
                o_wb_adr = data.adr;
                o_wb_sel = data_sel_bus;
                o_wb_dat = i_data_wdat; // Write data goes out as is.
        end

        default:
        begin
                o_wb_cyc = 1'b0; // Bus idle.
        end
        endcase
end

// Acknowledge only the channel that owns the bus.
assign code.ack  = i_wb_ack && (gnt_q == GNT_CODE);
assign data.ack  = i_wb_ack && (gnt_q == GNT_DATA);

assign code.rdat = rd_swp.word;
assign data.rdat = rd_swp.word;

endmodule

`default_nettype wire
